//--- blit_state.f
+incdir+verilog
verilog/blit_pkg.sv
verilog/blit_cmd_regs.sv
verilog/blit_outer.sv
verilog/blit_inner.sv
verilog/blit_mem_ctrl.sv
verilog/blit_state.sv
tests/blit_state_tb.sv

//--- Bender.yml
package:
  name: blit_state

export_include_dirs:
  - verilog

sources:
  - verilog/blit_pkg.sv
  - verilog/blit_cmd_regs.sv
  - verilog/blit_outer.sv
  - verilog/blit_inner.sv
  - verilog/blit_mem_ctrl.sv
  - verilog/blit_state.sv
  - target: test
    files:
      - tests/blit_state_tb.sv

//--- tests/blit_state_tb.sv
// Blitter sequencer testbench with clock, reset, random stimulus, memory responder, model and checks
`include "blit_defines.svh"

module blit_state_tb;
	import blit_pkg::*;

	localparam int NUM_BLITS = 20;
	// Blits x pixels x cycles per pixel x cycles per memory cycle, plus margin
	localparam int TIMEOUT_CYCLES = NUM_BLITS * 12 * 3 * 8 + 2000;
	localparam logic [31:0] SEED = 32'hcad14e87;

	logic      clk;
	logic      rst_n;
	gpu_word_t gpu_din;
	logic      cmdld;
	logic      countld;
	logic      statrd;
	logic      blit_back;
	logic      ack;
	gpu_word_t gpu_dout;
	logic      blit_breq;
	logic      mem_req;
	mem_kind_t mem_kind;
	logic      blit_int;

	integer    seed;
	integer    resp_seed;	// Memory responder has its own stream
	mem_kind_t exp_kinds[$];
	mem_kind_t exp_kind;
	logic      prev_req;
	mem_kind_t prev_kind;
	int        grant_wait;
	int        ack_wait;
	int        int_count;
	int        exp_ints;
	int        cycle_count = 0;
	gpu_word_t status;

	blit_state i_blit_state (
		.clk       (clk),
		.rst_n     (rst_n),
		.gpu_din   (gpu_din),
		.cmdld     (cmdld),
		.countld   (countld),
		.statrd    (statrd),
		.blit_back (blit_back),
		.ack       (ack),
		.gpu_dout  (gpu_dout),
		.blit_breq (blit_breq),
		.mem_req   (mem_req),
		.mem_kind  (mem_kind),
		.blit_int  (blit_int)
	);

	always #50 clk = ~clk;

	task automatic halt_on_error();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
		halt_on_error();
	endtask

	task automatic failure(input string msg);
		$display("%s", msg);
		halt_on_error();
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			failure("Timeout, the blits did not finish within the cycle limit");
		end
	end

	// Expected kinds of one blit, pixel by pixel and line by line
	task automatic expand_blit(input logic srcen, input logic dsten,
		input int inner, input int outer);
		for (int l = 0; l < outer; l++) begin
			for (int p = 0; p < inner; p++) begin
				if (srcen) exp_kinds.push_back(MEM_SRC_READ);
				if (dsten) exp_kinds.push_back(MEM_DST_READ);
				exp_kinds.push_back(MEM_DST_WRITE);
			end
		end
	endtask

	// Bus monitor and memory responder
	// Inputs read here still hold the values seen at the last rising edge
	always @(negedge clk) begin
		if (mem_req && !prev_req) begin
			assert (blit_back) else failure("mem_req was raised while blit_back was low");
		end
		if (prev_req && !ack) begin
			assert (mem_req) else failure("mem_req dropped before its ack");
			assert (mem_kind == prev_kind) else mismatch("mem_kind", mem_kind, prev_kind);
		end
		if (prev_req && ack) begin
			assert (!mem_req) else mismatch("mem_req", mem_req, 1'b0);
			assert (exp_kinds.size() > 0)
				else failure("Memory cycle acknowledged with none expected");
			exp_kind = exp_kinds.pop_front();
			assert (prev_kind == exp_kind) else mismatch("mem_kind", prev_kind, exp_kind);
			if (exp_kinds.size() == 0) begin
				// Interrupt one cycle after the last write's ack
				assert (blit_int) else mismatch("blit_int", blit_int, 1'b1);
			end
		end
		if (blit_int) begin
			assert (exp_kinds.size() == 0)
				else failure("blit_int came before the last expected write");
			assert (!blit_breq) else mismatch("blit_breq", blit_breq, 1'b0);
			int_count++;
		end
		prev_req = mem_req;
		prev_kind = mem_kind;

		if (!blit_breq) begin
			blit_back = 1'b0;
		end else if (!blit_back) begin
			if (grant_wait == 0) begin
				blit_back = 1'b1;
				grant_wait = $unsigned($random(resp_seed)) % 4;
			end else begin
				grant_wait--;
			end
		end else if ($unsigned($random(resp_seed)) % 4 == 0) begin
			blit_back = 1'b0;	// Grant taken away for a while
		end

		if (ack) begin
			ack = 1'b0;
			ack_wait = $unsigned($random(resp_seed)) % 4;
		end else if (mem_req) begin
			if (ack_wait == 0) ack = 1'b1;
			else ack_wait--;
		end
	end

	task automatic read_status(output gpu_word_t word);
		statrd = 1'b1;
		@(negedge clk);
		word = gpu_dout;
		statrd = 1'b0;
	endtask

	task automatic run_blit();
		int        inner;
		int        outer;
		int        r;
		gpu_word_t cmd_word;
		gpu_word_t word;
		logic      injected;
		logic      done;

		inner = $unsigned($random(seed)) % 5;
		outer = $unsigned($random(seed)) % 4;
		cmd_word = $random(seed);
		expand_blit(cmd_word[`BLIT_SRCEN_BIT], cmd_word[`BLIT_DSTEN_BIT], inner, outer);
		exp_ints++;

		gpu_din = {blit_count_t'(outer), blit_count_t'(inner)};
		countld = 1'b1;
		@(negedge clk);
		countld = 1'b0;
		gpu_din = cmd_word;
		cmdld = 1'b1;
		injected = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (statrd) begin
				assert (gpu_dout[0] == 1'b0) else mismatch("gpu_dout idle", gpu_dout[0], 1'b0);
			end
			cmdld = 1'b0;
			statrd = 1'b0;
			if (blit_int) begin
				done = 1'b1;
			end else begin
				r = $unsigned($random(seed)) % 8;
				if (r == 0 && blit_breq && !injected) begin
					gpu_din = $random(seed);	// Command write while busy
					cmdld = 1'b1;
					injected = 1'b1;
				end else if (r == 1 && blit_breq && !mem_req) begin
					// No request pending, so no ack can end the blit before the read
					statrd = 1'b1;
				end
			end
		end

		read_status(word);
		assert (word == 32'h1) else mismatch("gpu_dout", word, 32'h1);
		assert (exp_kinds.size() == 0)
			else failure("Blit ended with memory cycles still expected");
		assert (int_count == exp_ints) else mismatch("blit_int count", int_count, exp_ints);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		gpu_din = '0;
		cmdld = 1'b0;
		countld = 1'b0;
		statrd = 1'b0;
		blit_back = 1'b0;
		ack = 1'b0;
		seed = SEED;
		resp_seed = SEED;
		prev_req = 1'b0;
		grant_wait = 0;
		ack_wait = 0;
		int_count = 0;
		exp_ints = 0;

		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!blit_breq) else mismatch("blit_breq", blit_breq, 1'b0);
		assert (!mem_req) else mismatch("mem_req", mem_req, 1'b0);
		assert (!blit_int) else mismatch("blit_int", blit_int, 1'b0);
		read_status(status);
		assert (status == 32'h1) else mismatch("gpu_dout", status, 32'h1);

		for (int b = 0; b < NUM_BLITS; b++) begin
			run_blit();
			repeat (2) @(negedge clk);
		end

		repeat (4) @(negedge clk);
		assert (int_count == exp_ints) else mismatch("blit_int count", int_count, exp_ints);
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- verilog/blit_state.sv
// Blitter sequencer top with register block, outer and inner loops and memory control
`include "blit_defines.svh"

module blit_state (
	input  logic                clk,
	input  logic                rst_n,
	input  blit_pkg::gpu_word_t gpu_din,
	input  logic                cmdld,
	input  logic                countld,
	input  logic                statrd,
	input  logic                blit_back,
	input  logic                ack,
	output blit_pkg::gpu_word_t gpu_dout,
	output logic                blit_breq,
	output logic                mem_req,
	output blit_pkg::mem_kind_t mem_kind,
	output logic                blit_int
);
	import blit_pkg::*;

	logic         start;
	blit_cmd_t    cmd;
	blit_counts_t counts;
	logic         busy;
	logic         line_start;
	logic         line_done;
	blit_count_t  inner_left;
	blit_count_t  outer_left;
	logic         cycle_req;
	mem_kind_t    cycle_kind;
	logic         cycle_done;

	blit_cmd_regs i_blit_cmd_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.gpu_din    (gpu_din),
		.cmdld      (cmdld),
		.countld    (countld),
		.statrd     (statrd),
		.busy       (busy),
		.inner_left (inner_left),
		.outer_left (outer_left),
		.cmd        (cmd),
		.counts     (counts),
		.start      (start),
		.gpu_dout   (gpu_dout)
	);

	blit_outer i_blit_outer (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.counts     (counts),
		.line_done  (line_done),
		.line_start (line_start),
		.busy       (busy),
		.outer_left (outer_left),
		.blit_int   (blit_int)
	);

	blit_inner i_blit_inner (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.cmd        (cmd),
		.counts     (counts),
		.cycle_done (cycle_done),
		.cycle_req  (cycle_req),
		.cycle_kind (cycle_kind),
		.inner_left (inner_left),
		.line_done  (line_done)
	);

	blit_mem_ctrl i_blit_mem_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.busy       (busy),
		.blit_back  (blit_back),
		.ack        (ack),
		.cycle_req  (cycle_req),
		.cycle_kind (cycle_kind),
		.blit_breq  (blit_breq),
		.mem_req    (mem_req),
		.mem_kind   (mem_kind),
		.cycle_done (cycle_done)
	);

endmodule

//--- verilog/blit_mem_ctrl.sv
// Memory side control with bus request, granted cycle launch and hold until acknowledge
`include "blit_defines.svh"

module blit_mem_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                busy,
	input  logic                blit_back,
	input  logic                ack,
	input  logic                cycle_req,
	input  blit_pkg::mem_kind_t cycle_kind,
	output logic                blit_breq,
	output logic                mem_req,
	output blit_pkg::mem_kind_t mem_kind,
	output logic                cycle_done
);

	logic launch;

	// Bus wanted for the whole blit, released with the interrupt
	assign blit_breq = busy;

	// New cycle only on a granted bus with nothing in flight
	// A raised request is never withdrawn, even if the grant drops
	assign launch = cycle_req && blit_breq && blit_back && !mem_req;

	assign cycle_done = mem_req && ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_req <= 1'b0;
		end else if (launch) begin
			mem_req <= 1'b1;
		end else if (cycle_done) begin
			mem_req <= 1'b0;	// Cycle ends with its ack
		end
	end

	// Kind is frozen for the life of the request
	always_ff @(posedge clk) begin
		if (launch) begin
			mem_kind <= cycle_kind;
		end
	end

	// The earliest relaunch is one cycle after an ack, as launch needs
	// mem_req low and the inner phase has moved on by then

endmodule

//--- verilog/blit_inner.sv
// Inner loop controller with pixel count and memory cycle phase sequencing
`include "blit_defines.svh"

module blit_inner (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   line_start,
	input  blit_pkg::blit_cmd_t    cmd,
	input  blit_pkg::blit_counts_t counts,
	input  logic                   cycle_done,
	output logic                   cycle_req,
	output blit_pkg::mem_kind_t    cycle_kind,
	output blit_pkg::blit_count_t  inner_left,
	output logic                   line_done
);
	import blit_pkg::*;

	pixel_phase_t phase;
	pixel_phase_t next_phase;
	pixel_phase_t first_phase;	// Entry phase of every pixel
	logic last_pixel;
	logic write_done;

	// Disabled reads are skipped, the write is always there
	assign first_phase = cmd.srcen ? PH_SRC : (cmd.dsten ? PH_DST : PH_WRITE);

	assign last_pixel = (inner_left == blit_count_t'(1));
	assign write_done = cycle_done && (phase == PH_WRITE);

	always_comb begin
		next_phase = phase;
		case (phase)
			PH_IDLE: begin
				if (line_start) begin
					next_phase = first_phase;
				end
			end
			PH_SRC: begin
				if (cycle_done) begin
					next_phase = cmd.dsten ? PH_DST : PH_WRITE;
				end
			end
			PH_DST: begin
				if (cycle_done) begin
					next_phase = PH_WRITE;
				end
			end
			PH_WRITE: begin
				if (cycle_done) begin
					next_phase = last_pixel ? PH_IDLE : first_phase;
				end
			end
			default: begin
				next_phase = PH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			inner_left <= '0;
		end else begin
			phase <= next_phase;
			if (line_start && (phase == PH_IDLE)) begin
				inner_left <= counts.inner;	// Reload per line
			end else if (write_done) begin
				inner_left <= inner_left - blit_count_t'(1);
			end
		end
	end

	// Ends the line in the ack cycle of its last write
	assign line_done = write_done && last_pixel;

	assign cycle_req = (phase != PH_IDLE);

	always_comb begin
		case (phase)
			PH_SRC:  cycle_kind = MEM_SRC_READ;
			PH_DST:  cycle_kind = MEM_DST_READ;
			default: cycle_kind = MEM_DST_WRITE;
		endcase
	end

endmodule

//--- verilog/blit_outer.sv
// Outer loop controller with line count, line start, blit completion and interrupt
`include "blit_defines.svh"

module blit_outer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  blit_pkg::blit_counts_t counts,
	input  logic                   line_done,
	output logic                   line_start,
	output logic                   busy,
	output blit_pkg::blit_count_t  outer_left,
	output logic                   blit_int
);
	import blit_pkg::*;

	logic empty;		// Nothing to draw
	logic last_line;

	assign empty = (counts.inner == '0) || (counts.outer == '0);
	assign last_line = (outer_left == blit_count_t'(1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			line_start <= 1'b0;
			blit_int <= 1'b0;
			outer_left <= '0;
		end else begin
			// Both strobes are single cycle
			line_start <= 1'b0;
			blit_int <= 1'b0;

			if (start) begin
				if (empty) begin
					outer_left <= '0;
					blit_int <= 1'b1;	// Ends without any memory cycle
				end else begin
					outer_left <= counts.outer;
					busy <= 1'b1;
					line_start <= 1'b1;	// First line
				end
			end else if (busy && line_done) begin
				outer_left <= outer_left - blit_count_t'(1);
				if (last_line) begin
					busy <= 1'b0;
					blit_int <= 1'b1;
				end else begin
					line_start <= 1'b1;
				end
			end
		end
	end

	// line_done comes straight from the last write ack, so the interrupt
	// and the bus release both land one cycle after that ack

endmodule

//--- verilog/blit_cmd_regs.sv
// Command and count registers, blit start pulse and status word readback
`include "blit_defines.svh"

module blit_cmd_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  blit_pkg::gpu_word_t    gpu_din,
	input  logic                   cmdld,
	input  logic                   countld,
	input  logic                   statrd,
	input  logic                   busy,
	input  blit_pkg::blit_count_t  inner_left,
	input  blit_pkg::blit_count_t  outer_left,
	output blit_pkg::blit_cmd_t    cmd,
	output blit_pkg::blit_counts_t counts,
	output logic                   start,
	output blit_pkg::gpu_word_t    gpu_dout
);
	import blit_pkg::*;

	logic accept;	// Command write that starts a blit
	logic idle;

	// A command write while a blit runs is dropped
	// The start cycle itself counts as running, busy is not up yet
	assign accept = cmdld & ~busy & ~start;
	assign idle = ~busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start <= 1'b0;
			cmd <= '0;
		end else begin
			start <= accept;
			if (accept) begin
				cmd.srcen <= gpu_din[`BLIT_SRCEN_BIT];
				cmd.dsten <= gpu_din[`BLIT_DSTEN_BIT];
			end
		end
	end

	// Count word, lines in bits 31..16 and pixels in bits 15..0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			counts <= '0;
		end else if (countld) begin
			counts <= blit_counts_t'(gpu_din);
		end
	end

	// Status word
	// Pixels left on top, then the low bits of lines left, idle in bit 0
	assign gpu_dout = statrd ?
		gpu_word_t'({inner_left, outer_left[`BLIT_COUNT_W-2:0], idle}) : '0;

endmodule

//--- verilog/blit_pkg.sv
// Bus word and count types, command and count structs, memory cycle and pixel phase enums
`include "blit_defines.svh"

package blit_pkg;

	// One processor bus word
	typedef logic [`BLIT_DATA_W-1:0] gpu_word_t;

	typedef logic [`BLIT_COUNT_W-1:0] blit_count_t;

	// Command bits used by the sequencer
	typedef struct packed {
		logic srcen;	// Source read per pixel
		logic dsten;	// Destination read per pixel
	} blit_cmd_t;

	// Count word layout, lines in the upper half
	typedef struct packed {
		blit_count_t outer;
		blit_count_t inner;
	} blit_counts_t;

	typedef enum logic [1:0] {
		MEM_SRC_READ  = 2'd0,
		MEM_DST_READ  = 2'd1,
		MEM_DST_WRITE = 2'd2
	} mem_kind_t;

	// Inner loop phases, one per memory cycle
	typedef enum logic [1:0] {
		PH_IDLE  = 2'd0,
		PH_SRC   = 2'd1,
		PH_DST   = 2'd2,
		PH_WRITE = 2'd3
	} pixel_phase_t;

endpackage

//--- verilog/blit_defines.svh
// Bus and count widths, command bit positions
`ifndef BLIT_DEFINES_SVH
`define BLIT_DEFINES_SVH

// Processor data bus
`define BLIT_DATA_W 32

// Width of each half of the count word
`define BLIT_COUNT_W 16

// Command word bit that turns on the source read of each pixel
`define BLIT_SRCEN_BIT 0

// Command word bit that turns on the destination read of each pixel
`define BLIT_DSTEN_BIT 3

`endif
